//--- mem_subsystem.f
hdl/mem_pkg.sv
hdl/frame_pkg.sv
hdl/sync_fifo.sv
hdl/mem_arbiter.sv
hdl/mem_store.sv
hdl/rect_fill.sv
hdl/mem_test.sv
hdl/line_reader.sv
hdl/mem_subsystem.sv
dv/tb_mem_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f mem_subsystem.f \
	--top-module tb_mem_subsystem --Mdir obj_dir -o tb_sim || { echo "Build failed"; exit 1; }

out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1

//--- dv/tb_mem_subsystem.sv
// Directed testbench for the memory subsystem with clock, reset, test tasks and compare tasks
`timescale 1ns/1ps

module tb_mem_subsystem;

localparam int TIMEOUT = 20000;
localparam int SIG_FILL = 0;
localparam int SIG_TEST = 1;
localparam int SIG_PIX_FULL = 2;
localparam int SIG_STORE_EMPTY = 4;

logic CLOCK_50;
logic rst_n;
logic fill_start, test_start, line_start, pix_pop;
mem_pkg::addr_t line;
logic fill_active, test_busy, test_fail;
frame_pkg::pixel_t pix;
frame_pkg::pix_level_t pix_level;
logic pix_empty, pix_full;
mem_pkg::queue_level_t store_level;
logic store_empty, store_full;

int errors = 0;
int checks = 0;
int tests_run = 0;
int tests_failed = 0;
int peak_level = 0;

mem_subsystem dut_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n),
	.fill_start(fill_start), .test_start(test_start),
	.line_start(line_start), .line(line), .pix_pop(pix_pop),
	.fill_active(fill_active), .test_busy(test_busy), .test_fail(test_fail),
	.pix(pix), .pix_level(pix_level), .pix_empty(pix_empty), .pix_full(pix_full),
	.store_level(store_level), .store_empty(store_empty), .store_full(store_full));

always #5 CLOCK_50 = ~CLOCK_50;

task automatic check_pixel(string name, frame_pkg::pixel_t exp, frame_pkg::pixel_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic check_flag(string name, logic exp, logic act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
	end
endtask

task automatic check_level(string name, frame_pkg::pix_level_t exp, frame_pkg::pix_level_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
	end
endtask

task automatic check_store_level(string name, mem_pkg::queue_level_t exp,
	mem_pkg::queue_level_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
	end
endtask

// Inputs change 1 ns after the edge, outputs are read there too
task automatic tick();
	@(posedge CLOCK_50);
	#1;
	if (int'(pix_level) > peak_level)
		peak_level = int'(pix_level);
endtask

function automatic logic probe(int sel);
	case (sel)
		SIG_FILL: return fill_active;
		SIG_TEST: return test_busy;
		SIG_PIX_FULL: return pix_full;
		default: return store_empty;
	endcase
endfunction

task automatic wait_level(string what, int sel, logic level);
	int n;
	n = 0;
	while (probe(sel) !== level && n < TIMEOUT) begin
		tick();
		n++;
	end
	if (probe(sel) !== level) begin
		errors++;
		$display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
	end
endtask

task automatic pulse_starts(logic fill, logic test);
	fill_start = fill;
	test_start = test;
	tick();
	fill_start = 1'b0;
	test_start = 1'b0;
endtask

task automatic start_line(mem_pkg::addr_t row);
	line = row;
	line_start = 1'b1;
	tick();
	line_start = 1'b0;
endtask

function automatic mem_pkg::addr_t pick_row();
	return mem_pkg::addr_t'(frame_pkg::RECT_Y + $urandom_range(frame_pkg::RECT_H - 1));
endfunction

// Pops count pixels, each one expected to carry the fill colour
task automatic pop_pixels(string name, int count, bit slow);
	int got, idle, gap;
	got = 0;
	idle = 0;
	while (got < count && idle < TIMEOUT) begin
		if (!pix_empty) begin
			check_pixel(name, frame_pkg::pixel_t'(frame_pkg::FILL_COLOR), pix);
			pix_pop = 1'b1;
			got++;
			tick();
			pix_pop = 1'b0;
			gap = slow ? $urandom_range(4) : 0;
			repeat (gap) tick();
		end else begin
			tick();
			idle++;
		end
	end
	if (got < count)
		$display("Timed out in %s with %0d of %0d pixels", name, got, count);
	if (got < count)
		errors++;
endtask

task automatic end_test(string name, int errs_at_start);
	tests_run++;
	if (errors == errs_at_start) begin
		$display("%s: ok", name);
	end else begin
		tests_failed++;
		$display("%s: %0d error(s)", name, errors - errs_at_start);
	end
endtask

task automatic after_reset();
	int e0;
	e0 = errors;
	check_flag("after_reset fill_active", 1'b0, fill_active);
	check_flag("after_reset test_busy", 1'b0, test_busy);
	check_flag("after_reset test_fail", 1'b0, test_fail);
	check_flag("after_reset store_empty", 1'b1, store_empty);
	check_flag("after_reset store_full", 1'b0, store_full);
	check_flag("after_reset pix_empty", 1'b1, pix_empty);
	check_store_level("after_reset store_level", '0, store_level);
	end_test("after_reset", e0);
endtask

task automatic fill_then_scan();
	int e0;
	e0 = errors;
	pulse_starts(1'b1, 1'b0);
	check_flag("fill_then_scan fill_active", 1'b1, fill_active);
	wait_level("fill_active low", SIG_FILL, 1'b0);
	start_line(pick_row());
	pop_pixels("fill_then_scan pix", frame_pkg::LINE_WORDS, 1'b0);
	check_flag("fill_then_scan pix_empty", 1'b1, pix_empty);
	end_test("fill_then_scan", e0);
endtask

task automatic memory_check();
	int e0;
	e0 = errors;
	pulse_starts(1'b0, 1'b1);
	check_flag("memory_check test_busy", 1'b1, test_busy);
	wait_level("test_busy low", SIG_TEST, 1'b0);
	check_flag("memory_check test_fail", 1'b0, test_fail);
	end_test("memory_check", e0);
endtask

task automatic contention();
	int e0;
	e0 = errors;
	pulse_starts(1'b1, 1'b1);
	wait_level("fill_active low", SIG_FILL, 1'b0);
	start_line(pick_row());
	pop_pixels("contention pix", frame_pkg::LINE_WORDS, 1'b0);
	wait_level("test_busy low", SIG_TEST, 1'b0);
	check_flag("contention test_fail", 1'b0, test_fail);
	check_flag("contention pix_empty", 1'b1, pix_empty);
	end_test("contention", e0);
endtask

task automatic slow_consumer();
	int e0;
	e0 = errors;
	peak_level = 0;
	start_line(pick_row());
	// A whole line fits the FIFO exactly
	wait_level("pix_full high", SIG_PIX_FULL, 1'b1);
	// Second line has to wait until pops leave room for a burst
	start_line(pick_row());
	repeat (20) tick();
	check_flag("slow_consumer pix_full", 1'b1, pix_full);
	check_level("slow_consumer pix_level", frame_pkg::PIX_FIFO_DEPTH, pix_level);
	pop_pixels("slow_consumer pix", 2 * frame_pkg::LINE_WORDS, 1'b1);
	check_flag("slow_consumer peak within depth", 1'b1,
		peak_level <= frame_pkg::PIX_FIFO_DEPTH);
	check_flag("slow_consumer pix_empty", 1'b1, pix_empty);
	end_test("slow_consumer", e0);
endtask

task automatic return_to_idle();
	int e0;
	e0 = errors;
	wait_level("store_empty high", SIG_STORE_EMPTY, 1'b1);
	check_flag("return_to_idle store_empty", 1'b1, store_empty);
	check_flag("return_to_idle store_full", 1'b0, store_full);
	check_store_level("return_to_idle store_level", '0, store_level);
	check_flag("return_to_idle fill_active", 1'b0, fill_active);
	check_flag("return_to_idle test_busy", 1'b0, test_busy);
	end_test("return_to_idle", e0);
endtask

initial begin
	CLOCK_50 = 1'b0;
	rst_n = 1'b0;
	fill_start = 1'b0;
	test_start = 1'b0;
	line_start = 1'b0;
	line = '0;
	pix_pop = 1'b0;
	void'($urandom(32'heac7));
	repeat (5) tick();
	rst_n = 1'b1;
	tick();
	after_reset();
	fill_then_scan();
	memory_check();
	contention();
	slow_consumer();
	return_to_idle();
	$display("tests %0d, failed %0d, checks %0d, errors %0d",
		tests_run, tests_failed, checks, errors);
	if (errors == 0)
		$display("*** TEST PASSED ***");
	else
		$display("*** TEST FAILED ***");
	$finish;
end

endmodule

//--- hdl/mem_subsystem.sv
// Memory subsystem top with store, arbiter and the three memory clients
`timescale 1ns/1ps

module mem_subsystem (
	input logic CLOCK_50,
	input logic rst_n,
	input logic fill_start,
	input logic test_start,
	input logic line_start,
	input mem_pkg::addr_t line,
	input logic pix_pop,
	output logic fill_active,
	output logic test_busy,
	output logic test_fail,
	output frame_pkg::pixel_t pix,
	output frame_pkg::pix_level_t pix_level,
	output logic pix_empty,
	output logic pix_full,
	output mem_pkg::queue_level_t store_level,
	output logic store_empty,
	output logic store_full
);

logic [mem_pkg::N_CLIENTS-1:0] req, ack, valid;
mem_pkg::mem_req_t reqs [mem_pkg::N_CLIENTS];
logic cmd_valid, rsp_valid;
mem_pkg::mem_cmd_t cmd;
mem_pkg::mem_rsp_t rsp;
mem_pkg::data_t rsp_data;

mem_store store_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n),
	.cmd_valid(cmd_valid), .cmd(cmd), .rsp_valid(rsp_valid), .rsp(rsp),
	.level(store_level), .empty(store_empty), .full(store_full));

mem_arbiter arb_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n),
	.req(req), .reqs(reqs), .ack(ack), .cmd_valid(cmd_valid), .cmd(cmd),
	.store_full(store_full), .rsp_valid(rsp_valid), .rsp(rsp),
	.rsp_data(rsp_data), .valid(valid));

// Client 0
line_reader scan_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n),
	.line_start(line_start), .line(line),
	.req(req[mem_pkg::CLIENT_SCAN]), .mreq(reqs[mem_pkg::CLIENT_SCAN]),
	.ack(ack[mem_pkg::CLIENT_SCAN]), .rsp_data(rsp_data),
	.valid(valid[mem_pkg::CLIENT_SCAN]), .pix_pop(pix_pop), .pix(pix),
	.pix_level(pix_level), .pix_empty(pix_empty), .pix_full(pix_full));

// Client 1
rect_fill rect_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n), .start(fill_start),
	.req(req[mem_pkg::CLIENT_RECT]), .mreq(reqs[mem_pkg::CLIENT_RECT]),
	.ack(ack[mem_pkg::CLIENT_RECT]), .fill_active(fill_active));

// Client 2
mem_test test_i (.CLOCK_50(CLOCK_50), .rst_n(rst_n),
	.rsp_data(rsp_data), .valid(valid[mem_pkg::CLIENT_TEST]),
	.req(req[mem_pkg::CLIENT_TEST]), .mreq(reqs[mem_pkg::CLIENT_TEST]),
	.ack(ack[mem_pkg::CLIENT_TEST]), .start(test_start),
	.test_busy(test_busy), .test_fail(test_fail));

endmodule

//--- hdl/line_reader.sv
// Burst line reader feeding a pixel FIFO
`timescale 1ns/1ps

module line_reader (
	input logic CLOCK_50,
	input logic rst_n,
	input logic line_start,
	input mem_pkg::addr_t line,
	output logic req,
	output mem_pkg::mem_req_t mreq,
	input logic ack,
	input mem_pkg::data_t rsp_data,
	input logic valid,
	input logic pix_pop,
	output frame_pkg::pixel_t pix,
	output frame_pkg::pix_level_t pix_level,
	output logic pix_empty,
	output logic pix_full
);

logic issuing, room;
mem_pkg::addr_t row;
logic [$clog2(frame_pkg::LINE_BURSTS)-1:0] burst;
// Words acked but not yet returned
frame_pkg::pix_level_t pending;

sync_fifo #(
	.T(frame_pkg::pixel_t),
	.DEPTH(frame_pkg::PIX_FIFO_DEPTH)
) pix_fifo_i (
	.CLOCK_50(CLOCK_50),
	.rst_n(rst_n),
	.push(valid),
	.wdata(frame_pkg::pixel_t'(rsp_data)),
	.pop(pix_pop),
	.rdata(pix),
	.level(pix_level),
	.empty(pix_empty),
	.full(pix_full)
);

// Room for another burst after all words in flight land
assign room = int'(pix_level) + int'(pending) + mem_pkg::BURST <= frame_pkg::PIX_FIFO_DEPTH;
assign req = issuing && room;
assign mreq.addr = mem_pkg::addr_t'(frame_pkg::FB_BASE + int'(row) * frame_pkg::LINE_STRIDE
	+ frame_pkg::RECT_X + int'(burst) * mem_pkg::BURST);
assign mreq.data = '0;
assign mreq.wr = 1'b0;

always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		issuing <= 1'b0;
		burst <= '0;
		pending <= '0;
	end else begin
		if (!issuing && line_start) begin
			issuing <= 1'b1;
			burst <= '0;
		end else if (issuing && ack) begin
			burst <= burst + 1'b1;
			if (int'(burst) == frame_pkg::LINE_BURSTS - 1)
				issuing <= 1'b0;
		end
		pending <= frame_pkg::pix_level_t'(int'(pending)
			+ (ack ? mem_pkg::BURST : 0) - int'(valid));
	end
end

always_ff @(posedge CLOCK_50) begin
	if (!issuing && line_start)
		row <= line;
end

a_valid_expected: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
	valid |-> pending != '0);

endmodule

//--- hdl/mem_test.sv
// Memory test client with pattern writes and burst readback compare and a sticky fail flag
`timescale 1ns/1ps

module mem_test (
	input logic CLOCK_50,
	input logic rst_n,
	input mem_pkg::data_t rsp_data,
	input logic valid,
	output logic req,
	output mem_pkg::mem_req_t mreq,
	input logic ack,
	input logic start,
	output logic test_busy,
	output logic test_fail
);

typedef enum logic [1:0] {S_IDLE, S_WRITE, S_READ, S_DRAIN} state_t;

state_t state;
logic [$clog2(frame_pkg::TEST_LEN)-1:0] wr_idx, chk_idx;
logic [$clog2(frame_pkg::TEST_BURSTS)-1:0] rd_idx;
mem_pkg::addr_t wr_addr, rd_addr, chk_addr;

function automatic mem_pkg::data_t pattern(mem_pkg::addr_t a);
	return mem_pkg::data_t'(a) ^ frame_pkg::TEST_SALT;
endfunction

assign wr_addr = frame_pkg::TEST_BASE + mem_pkg::addr_t'(wr_idx);
assign rd_addr = frame_pkg::TEST_BASE + mem_pkg::addr_t'(int'(rd_idx) * mem_pkg::BURST);
// Store runs commands in order, so words come back in address order
assign chk_addr = frame_pkg::TEST_BASE + mem_pkg::addr_t'(chk_idx);

assign req = (state == S_WRITE) || (state == S_READ);
assign test_busy = state != S_IDLE;
assign mreq.wr = state == S_WRITE;
assign mreq.addr = (state == S_WRITE) ? wr_addr : rd_addr;
assign mreq.data = pattern(wr_addr);

always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		state <= S_IDLE;
		wr_idx <= '0;
		rd_idx <= '0;
		chk_idx <= '0;
		test_fail <= 1'b0;
	end else begin
		case (state)
			S_IDLE: if (start) begin
				state <= S_WRITE;
				wr_idx <= '0;
				rd_idx <= '0;
				chk_idx <= '0;
				test_fail <= 1'b0;
			end
			S_WRITE: if (ack) begin
				wr_idx <= wr_idx + 1'b1;
				if (int'(wr_idx) == frame_pkg::TEST_LEN - 1)
					state <= S_READ;
			end
			S_READ: if (ack) begin
				rd_idx <= rd_idx + 1'b1;
				if (int'(rd_idx) == frame_pkg::TEST_BURSTS - 1)
					state <= S_DRAIN;
			end
			S_DRAIN: if (valid && int'(chk_idx) == frame_pkg::TEST_LEN - 1)
				state <= S_IDLE;
			default: state <= S_IDLE;
		endcase
		// Compare each returned word
		if (valid && test_busy) begin
			chk_idx <= chk_idx + 1'b1;
			if (rsp_data != pattern(chk_addr))
				test_fail <= 1'b1;
		end
	end
end

a_data_after_read: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
	valid |-> state inside {S_READ, S_DRAIN});

endmodule

//--- hdl/rect_fill.sv
// Rectangle fill client writing the background colour one word per ack
`timescale 1ns/1ps

module rect_fill (
	input logic CLOCK_50,
	input logic rst_n,
	input logic start,
	output logic req,
	output mem_pkg::mem_req_t mreq,
	input logic ack,
	output logic fill_active
);

logic [$clog2(frame_pkg::RECT_W)-1:0] col;
logic [$clog2(frame_pkg::RECT_H)-1:0] row;
logic last_col, last_row;

assign last_col = int'(col) == frame_pkg::RECT_W - 1;
assign last_row = int'(row) == frame_pkg::RECT_H - 1;
assign req = fill_active;

// Current word of the rectangle
always_comb begin
	mreq.addr = mem_pkg::addr_t'(frame_pkg::FB_BASE
		+ (frame_pkg::RECT_Y + int'(row)) * frame_pkg::LINE_STRIDE
		+ frame_pkg::RECT_X + int'(col));
	mreq.data = frame_pkg::FILL_COLOR;
	mreq.wr = 1'b1;
end

always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		fill_active <= 1'b0;
		col <= '0;
		row <= '0;
	end else if (!fill_active) begin
		if (start) begin
			fill_active <= 1'b1;
			col <= '0;
			row <= '0;
		end
	end else if (ack) begin
		// Row by row, left to right
		if (last_col) begin
			col <= '0;
			row <= row + 1'b1;
			if (last_row)
				fill_active <= 1'b0;
		end else begin
			col <= col + 1'b1;
		end
	end
end

a_ack_while_active: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
	ack |-> fill_active);

endmodule

//--- hdl/mem_store.sv
// Memory store with command queue and word array for single writes and burst reads
`timescale 1ns/1ps

module mem_store (
	input logic CLOCK_50,
	input logic rst_n,
	input logic cmd_valid,
	input mem_pkg::mem_cmd_t cmd,
	output logic rsp_valid,
	output mem_pkg::mem_rsp_t rsp,
	output mem_pkg::queue_level_t level,
	output logic empty,
	output logic full
);

mem_pkg::data_t mem [mem_pkg::MEM_DEPTH];
mem_pkg::mem_cmd_t head, cur;
mem_pkg::addr_t rd_addr;
logic pop, busy;
logic [$clog2(mem_pkg::BURST)-1:0] beat;

sync_fifo #(
	.T(mem_pkg::mem_cmd_t),
	.DEPTH(mem_pkg::QUEUE_DEPTH)
) queue_i (
	.CLOCK_50(CLOCK_50),
	.rst_n(rst_n),
	.push(cmd_valid),
	.wdata(cmd),
	.pop(pop),
	.rdata(head),
	.level(level),
	.empty(empty),
	.full(full)
);

// Next command taken once the current one is done
assign pop = !busy && !empty;
// Address wraps within MEM_DEPTH through the address width
assign rd_addr = cur.req.addr + mem_pkg::addr_t'(beat);

always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		busy <= 1'b0;
		beat <= '0;
		rsp_valid <= 1'b0;
	end else begin
		rsp_valid <= 1'b0;
		if (pop) begin
			busy <= 1'b1;
			beat <= '0;
		end else if (busy) begin
			if (cur.req.wr) begin
				busy <= 1'b0;
			end else begin
				rsp_valid <= 1'b1;
				beat <= beat + 1'b1;
				if (int'(beat) == mem_pkg::BURST - 1)
					busy <= 1'b0;
			end
		end
	end
end

always_ff @(posedge CLOCK_50) begin
	if (pop)
		cur <= head;
	if (busy && cur.req.wr)
		mem[cur.req.addr] <= cur.req.data;
	rsp.data <= mem[rd_addr];
	rsp.client <= cur.client;
end

a_no_cmd_when_full: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
	cmd_valid |-> !full);

endmodule

//--- hdl/mem_arbiter.sv
// Round-robin memory request arbiter and read data routing to the owning client
`timescale 1ns/1ps

module mem_arbiter (
	input logic CLOCK_50,
	input logic rst_n,
	input logic [mem_pkg::N_CLIENTS-1:0] req,
	input mem_pkg::mem_req_t reqs [mem_pkg::N_CLIENTS],
	output logic [mem_pkg::N_CLIENTS-1:0] ack,
	output logic cmd_valid,
	output mem_pkg::mem_cmd_t cmd,
	input logic store_full,
	input logic rsp_valid,
	input mem_pkg::mem_rsp_t rsp,
	output mem_pkg::data_t rsp_data,
	output logic [mem_pkg::N_CLIENTS-1:0] valid
);

mem_pkg::client_t last, pick;
logic hit, grant;

// Search starts just after the previous winner
always_comb begin
	hit = 1'b0;
	pick = last;
	for (int i = 1; i <= mem_pkg::N_CLIENTS; i++) begin
		if (!hit && req[(int'(last) + i) % mem_pkg::N_CLIENTS]) begin
			hit = 1'b1;
			pick = mem_pkg::client_t'((int'(last) + i) % mem_pkg::N_CLIENTS);
		end
	end
end

// Only one command in flight, so store_full already counts it and
// the acked client's old request is not granted twice
assign grant = hit && !store_full && !cmd_valid;

always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		ack <= '0;
		cmd_valid <= 1'b0;
		last <= mem_pkg::client_t'(mem_pkg::N_CLIENTS - 1);
	end else begin
		ack <= '0;
		cmd_valid <= grant;
		if (grant) begin
			ack[pick] <= 1'b1;
			last <= pick;
		end
	end
end

always_ff @(posedge CLOCK_50) begin
	if (grant) begin
		cmd.client <= pick;
		cmd.req <= reqs[pick];
	end
end

// Shared data bus with a valid per client
assign rsp_data = rsp.data;
always_comb begin
	for (int i = 0; i < mem_pkg::N_CLIENTS; i++)
		valid[i] = rsp_valid && (int'(rsp.client) == i);
end

// Ack one-hot or zero and only to a client still holding req
a_ack_onehot: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
	$onehot0(ack) && (ack & ~req) == '0);

endmodule

//--- hdl/sync_fifo.sv
// Synchronous FIFO with first-word-fall-through output and level, empty and full flags
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T = logic [15:0],
	parameter int DEPTH = 4
) (
	input logic CLOCK_50,
	input logic rst_n,
	input logic push,
	input T wdata,
	input logic pop,
	output T rdata,
	output logic [$clog2(DEPTH + 1)-1:0] level,
	output logic empty,
	output logic full
);

// DEPTH is a power of two so the pointers wrap on their own
T mem [DEPTH];
logic [$clog2(DEPTH)-1:0] wr_ptr, rd_ptr;

always_ff @(posedge CLOCK_50) begin
	if (push)
		mem[wr_ptr] <= wdata;
end

always_ff @(posedge CLOCK_50 or negedge rst_n) begin
	if (!rst_n) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		level <= '0;
	end else begin
		if (push)
			wr_ptr <= wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= rd_ptr + 1'b1;
		case ({push, pop})
			2'b10: level <= level + 1'b1;
			2'b01: level <= level - 1'b1;
			default: ;
		endcase
	end
end

assign rdata = mem[rd_ptr];
assign empty = level == '0;
assign full = int'(level) == DEPTH;

a_no_overflow: assert property (@(posedge CLOCK_50) disable iff (!rst_n) !(push && full));
a_no_underflow: assert property (@(posedge CLOCK_50) disable iff (!rst_n) !(pop && empty));

endmodule

//--- hdl/frame_pkg.sv
// Frame-buffer geometry and fill rectangle with the memory test region and pixel types
package frame_pkg;

localparam int FB_BASE = 0;
localparam int LINE_STRIDE = 64;

// Fill rectangle in words
localparam int RECT_X = 16;
localparam int RECT_Y = 4;
localparam int RECT_W = 32;
localparam int RECT_H = 6;
localparam logic [15:0] FILL_COLOR = 16'h0841;

// Line reader starts at column RECT_X
localparam int LINE_WORDS = RECT_W;
localparam int LINE_BURSTS = LINE_WORDS / mem_pkg::BURST;
localparam int PIX_FIFO_DEPTH = 32;

// Test region and its pattern salt
localparam mem_pkg::addr_t TEST_BASE = 12'h800;
localparam int TEST_LEN = 64;
localparam int TEST_BURSTS = TEST_LEN / mem_pkg::BURST;
localparam logic [15:0] TEST_SALT = 16'h5a3c;

// RGB565
typedef struct packed {
	logic [4:0] r;
	logic [5:0] g;
	logic [4:0] b;
} pixel_t;

typedef logic [$clog2(PIX_FIFO_DEPTH + 1)-1:0] pix_level_t;

endpackage

//--- hdl/mem_pkg.sv
// Memory bus widths and burst length with client indices and the request, command and response structs
package mem_pkg;

// Word-addressed store
localparam int ADDR_W = 12;
localparam int DATA_W = 16;
localparam int MEM_DEPTH = 4096;
localparam int BURST = 8;
localparam int QUEUE_DEPTH = 4;

// Arbiter ports
localparam int N_CLIENTS = 3;
localparam int CLIENT_SCAN = 0;
localparam int CLIENT_RECT = 1;
localparam int CLIENT_TEST = 2;

typedef logic [ADDR_W-1:0] addr_t;
typedef logic [DATA_W-1:0] data_t;
typedef logic [1:0] client_t;
typedef logic [$clog2(QUEUE_DEPTH + 1)-1:0] queue_level_t;

// Held by a client while req is high
typedef struct packed {
	addr_t addr;
	data_t data;
	logic wr;
} mem_req_t;

typedef struct packed {
	client_t client;
	mem_req_t req;
} mem_cmd_t;

typedef struct packed {
	client_t client;
	data_t data;
} mem_rsp_t;

endpackage
